// ==== common/alu_pkg.sv ====
package alu_pkg;

	// **********************************************************
	// widths
	// **********************************************************
	localparam int data_width        = 32;
	localparam int addr_width        = 5;
	localparam int alu_control_width = 3;
	localparam int func_width        = 6;
	localparam int flag_width        = 3;
	localparam int prod_width        = 2 * data_width; // full multiply product.
	localparam int strb_width        = data_width / 8;

	// **********************************************************
	// opcodes (alu_control)
	// **********************************************************
	localparam logic [alu_control_width-1:0] op_addi   = 3'd0;
	localparam logic [alu_control_width-1:0] op_subi   = 3'd1;
	localparam logic [alu_control_width-1:0] op_type_r = 3'd2; // selected by func.
	localparam logic [alu_control_width-1:0] op_andi   = 3'd3;
	localparam logic [alu_control_width-1:0] op_ori    = 3'd4;
	localparam logic [alu_control_width-1:0] op_brfl   = 3'd5; // branch on flag.
	localparam logic [alu_control_width-1:0] op_cmp    = 3'd6;

	// r-type function codes.
	localparam logic [func_width-1:0] fn_add = 6'b100000;
	localparam logic [func_width-1:0] fn_sub = 6'b100010;
	localparam logic [func_width-1:0] fn_mul = 6'b000010;
	localparam logic [func_width-1:0] fn_div = 6'b000001;
	localparam logic [func_width-1:0] fn_and = 6'b100100;
	localparam logic [func_width-1:0] fn_or  = 6'b100101;
	localparam logic [func_width-1:0] fn_not = 6'b100111;

	// condition flag codes.
	localparam logic [flag_width-1:0] flag_none      = 3'd0;
	localparam logic [flag_width-1:0] flag_equal     = 3'd1;
	localparam logic [flag_width-1:0] flag_exception = 3'd2; // divide by zero.
	localparam logic [flag_width-1:0] flag_overflow  = 3'd3;
	localparam logic [flag_width-1:0] flag_underflow = 3'd4;
	localparam logic [flag_width-1:0] flag_above     = 3'd5;

	// **********************************************************
	// register map
	// **********************************************************
	localparam logic [addr_width-1:0] reg_data_a = 5'h00;
	localparam logic [addr_width-1:0] reg_data_b = 5'h04;
	localparam logic [addr_width-1:0] reg_op     = 5'h08;
	localparam logic [addr_width-1:0] reg_result = 5'h0C; // read only.
	localparam logic [addr_width-1:0] reg_status = 5'h10; // read only.

	// field positions inside the op word and the status word.
	localparam int op_ctl_lsb        = 0;
	localparam int op_func_lsb       = 8;
	localparam int status_flag_lsb   = 0;
	localparam int status_branch_bit = 4;

	// axi response code, always okay here.
	localparam logic [1:0] axi_resp_okay = 2'b00;

endpackage

// ==== alu/alu.sv ====
`timescale 1ns/100ps

module alu import alu_pkg::*; (
	input  logic [data_width-1:0]        data_a,
	input  logic [data_width-1:0]        data_b,
	input  logic [alu_control_width-1:0] alu_control,
	input  logic [func_width-1:0]        func,
	output logic [data_width-1:0]        alu_result,
	output logic [flag_width-1:0]        new_flag,
	output logic                         flag_update
);

	logic [data_width:0]     add_sum;  // carry in the top bit.
	logic [data_width:0]     sub_diff;
	logic [prod_width-1:0]   product;
	logic [data_width-1:0]   quotient;
	logic                    div_zero;
	logic [flag_width-1:0]   add_flag;
	logic [flag_width-1:0]   sub_flag;
	logic [flag_width-1:0]   mul_flag;
	logic [flag_width-1:0]   div_flag;
	logic [flag_width-1:0]   cmp_flag;

	// carry and sign bit of a 33-bit sum to a flag.
	function automatic logic [flag_width-1:0] carry_flag(input logic [1:0] carry_sign);
		case (carry_sign)
			2'b00:   carry_flag = flag_none;
			2'b10:   carry_flag = flag_underflow;
			default: carry_flag = flag_overflow; // 01 and 11.
		endcase
	endfunction

	// **********************************************************
	// datapath
	// **********************************************************
	assign add_sum  = {1'b0, data_a} + {1'b0, data_b};
	assign sub_diff = {1'b0, data_a} - {1'b0, data_b};
	assign product  = {{data_width{1'b0}}, data_a} * {{data_width{1'b0}}, data_b};

	assign div_zero = (data_b == '0);
	assign quotient = div_zero ? '1 : data_a / data_b; // all ones on divide by zero.

	assign add_flag = carry_flag({add_sum[data_width], add_sum[data_width-1]});
	assign sub_flag = carry_flag({sub_diff[data_width], sub_diff[data_width-1]});

	// upper product word nonzero means the low word lost information.
	assign mul_flag = (product[prod_width-1:data_width] != '0) ? flag_overflow : flag_none;
	assign div_flag = div_zero ? flag_exception : flag_none;

	always_comb begin
		if (data_a == data_b) begin
			cmp_flag = flag_equal;
		end else if (data_a > data_b) begin
			cmp_flag = flag_above; // unsigned.
		end else begin
			cmp_flag = flag_none;
		end
	end

	// **********************************************************
	// op select
	// **********************************************************
	always_comb begin
		alu_result  = '0;
		new_flag    = flag_none;
		flag_update = 1'b0;
		case (alu_control)
			op_addi: begin
				alu_result  = add_sum[data_width-1:0];
				new_flag    = add_flag;
				flag_update = 1'b1;
			end
			op_subi: begin
				alu_result  = sub_diff[data_width-1:0];
				new_flag    = sub_flag;
				flag_update = 1'b1;
			end
			op_type_r: begin
				case (func)
					fn_add: begin
						alu_result  = add_sum[data_width-1:0];
						new_flag    = add_flag;
						flag_update = 1'b1;
					end
					fn_sub: begin
						alu_result  = sub_diff[data_width-1:0];
						new_flag    = sub_flag;
						flag_update = 1'b1;
					end
					fn_mul: begin
						alu_result  = product[data_width-1:0];
						new_flag    = mul_flag;
						flag_update = 1'b1;
					end
					fn_div: begin
						alu_result  = quotient;
						new_flag    = div_flag;
						flag_update = 1'b1;
					end
					fn_and:  alu_result = data_a & data_b; // logic ops keep the flag.
					fn_or:   alu_result = data_a | data_b;
					fn_not:  alu_result = ~data_b;
					default: alu_result = '0;
				endcase
			end
			op_andi: alu_result = data_a & data_b;
			op_ori:  alu_result = data_a | data_b;
			op_cmp: begin
				new_flag    = cmp_flag; // result stays zero.
				flag_update = 1'b1;
			end
			op_brfl: alu_result = data_a;
			default: alu_result = '0;
		endcase
	end

endmodule

// ==== alu/flag_unit.sv ====
`timescale 1ns/100ps

module flag_unit import alu_pkg::*; (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         execute,
	input  logic [alu_control_width-1:0] alu_control,
	input  logic [data_width-1:0]        data_b,
	input  logic [flag_width-1:0]        new_flag,
	input  logic                         flag_update,
	output logic [flag_width-1:0]        flag,
	output logic                         branch
);

	logic is_brfl;
	logic flag_match;

	assign is_brfl = (alu_control == op_brfl);

	// branch tests the flag as stored before this operation.
	assign flag_match = (flag == data_b[flag_width-1:0]);

	// **********************************************************
	// persistent flag and branch decision
	// **********************************************************
	always_ff @(posedge clock) begin
		if (!reset) begin
			flag   <= flag_none;
			branch <= 1'b0;
		end else if (execute) begin
			if (flag_update) begin
				flag <= new_flag;
			end
			// any other executed op clears the branch.
			branch <= is_brfl && flag_match;
		end
	end

endmodule

// ==== design/alu_axi_regs.sv ====
`timescale 1ns/100ps

module alu_axi_regs import alu_pkg::*; (
	input  logic                         clock,
	input  logic                         reset,
	// write address
	input  logic [addr_width-1:0]        awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	// write data
	input  logic [data_width-1:0]        wdata,
	input  logic [strb_width-1:0]        wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	// write response
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	// read address
	input  logic [addr_width-1:0]        araddr,
	input  logic                         arvalid,
	output logic                         arready,
	// read data
	output logic [data_width-1:0]        rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready,
	// to alu and flag unit
	output logic [data_width-1:0]        data_a,
	output logic [data_width-1:0]        data_b,
	output logic [alu_control_width-1:0] alu_control,
	output logic [func_width-1:0]        func,
	input  logic [data_width-1:0]        alu_result,
	input  logic [flag_width-1:0]        flag,
	input  logic                         branch,
	output logic                         execute
);

	logic [data_width-1:0] data_a_q;
	logic [data_width-1:0] data_b_q;
	logic [data_width-1:0] op_q;
	logic [data_width-1:0] result_q;
	logic [data_width-1:0] op_word;
	logic [data_width-1:0] rd_word;
	logic                  wr_en;
	logic                  wr_pending;

	// **********************************************************
	// write channel
	// **********************************************************
	assign wr_pending = awvalid && wvalid && !bvalid;
	assign wr_en      = awready && awvalid && wready && wvalid;
	assign execute    = wr_en && (awaddr == reg_op);

	// aw and w are taken together, one per response.
	always_ff @(posedge clock) begin
		if (!reset) begin
			awready <= 1'b0;
			wready  <= 1'b0;
		end else begin
			awready <= !awready && wr_pending;
			wready  <= !wready && wr_pending;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			bvalid <= 1'b0;
		end else if (wr_en) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	assign bresp = axi_resp_okay;

	// strobes ignored; only full-word writes are used.
	always_ff @(posedge clock) begin
		if (!reset) begin
			data_a_q <= '0;
			data_b_q <= '0;
			op_q     <= '0;
			result_q <= '0;
		end else if (wr_en) begin
			case (awaddr)
				reg_data_a: data_a_q <= wdata;
				reg_data_b: data_b_q <= wdata;
				reg_op: begin
					op_q     <= wdata;
					result_q <= alu_result; // alu already sees the new op word.
				end
				default: ; // read-only or unmapped.
			endcase
		end
	end

	// new op word goes straight to the alu on the accept cycle.
	assign op_word     = execute ? wdata : op_q;
	assign data_a      = data_a_q;
	assign data_b      = data_b_q;
	assign alu_control = op_word[op_ctl_lsb +: alu_control_width];
	assign func        = op_word[op_func_lsb +: func_width];

	// **********************************************************
	// read channel
	// **********************************************************
	always_comb begin
		rd_word = '0; // unmapped reads zero.
		case (araddr)
			reg_data_a: rd_word = data_a_q;
			reg_data_b: rd_word = data_b_q;
			reg_op:     rd_word = op_q;
			reg_result: rd_word = result_q;
			reg_status: begin
				rd_word[status_flag_lsb +: flag_width] = flag;
				rd_word[status_branch_bit]             = branch;
			end
			default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
		end else if (arready && arvalid) begin
			arready <= 1'b0;
			rvalid  <= 1'b1;
			rdata   <= rd_word;
		end else if (rvalid && rready) begin
			rvalid  <= 1'b0;
			arready <= 1'b1;
		end else if (!rvalid) begin
			arready <= 1'b1;
		end
	end

	assign rresp = axi_resp_okay;

endmodule

// ==== design/alu_top.sv ====
`timescale 1ns/100ps

module alu_top import alu_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [addr_width-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [data_width-1:0] wdata,
	input  logic [strb_width-1:0] wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [addr_width-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [data_width-1:0] rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready
);

	logic [data_width-1:0]        data_a;
	logic [data_width-1:0]        data_b;
	logic [alu_control_width-1:0] alu_control;
	logic [func_width-1:0]        func;
	logic [data_width-1:0]        alu_result;
	logic [flag_width-1:0]        new_flag;
	logic                         flag_update;
	logic [flag_width-1:0]        flag;
	logic                         branch;
	logic                         execute;

	// **********************************************************
	// register block, alu and flag state
	// **********************************************************
	alu_axi_regs u_regs (
		.clock       (clock),
		.reset       (reset),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.data_a      (data_a),
		.data_b      (data_b),
		.alu_control (alu_control),
		.func        (func),
		.alu_result  (alu_result),
		.flag        (flag),
		.branch      (branch),
		.execute     (execute)
	);

	alu u_alu (
		.data_a      (data_a),
		.data_b      (data_b),
		.alu_control (alu_control),
		.func        (func),
		.alu_result  (alu_result),
		.new_flag    (new_flag),
		.flag_update (flag_update)
	);

	flag_unit u_flag (
		.clock       (clock),
		.reset       (reset),
		.execute     (execute),
		.alu_control (alu_control),
		.data_b      (data_b),
		.new_flag    (new_flag),
		.flag_update (flag_update),
		.flag        (flag),
		.branch      (branch)
	);

endmodule

// ==== dv/alu_tb.sv ====
`timescale 1ns/100ps

module alu_tb import alu_pkg::*; ();

	localparam int clk_period      = 100;
	localparam int random_cases    = 16;
	localparam int cycles_per_case = 200;

	// r-type codes picked by the random cases, fn_add at index 0.
	localparam logic [6:0][func_width-1:0] r_funcs =
		{fn_not, fn_or, fn_and, fn_div, fn_mul, fn_sub, fn_add};

	logic                  clock;
	logic                  reset;
	logic [addr_width-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [data_width-1:0] wdata;
	logic [strb_width-1:0] wstrb;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [addr_width-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [data_width-1:0] rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;

	// test table, one entry per index.
	string                        name_q[$];
	logic [data_width-1:0]        a_q[$];
	logic [data_width-1:0]        b_q[$];
	logic [alu_control_width-1:0] ctl_q[$];
	logic [func_width-1:0]        fn_q[$];
	logic [data_width-1:0]        res_q[$];
	logic [flag_width-1:0]        flag_q[$];
	logic                         br_q[$];

	logic [flag_width-1:0] stored_flag; // flag held after the last table entry.
	logic [31:0]           lcg_state;
	int                    error_count;
	bit                    table_ready;

	alu_top dut (.*);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	initial begin
		wait (table_ready);
		#((name_q.size() + 8) * cycles_per_case * clk_period);
		$display("timeout: the DUT stopped answering before all tests were done");
		$display("test failed");
		$fatal(1);
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input string field,
		input logic [data_width-1:0] expected, input logic [data_width-1:0] actual);
		assert (actual === expected) else begin
			error_count++;
			$display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic stop_with_error(input string what);
		error_count++;
		$display("error: %s", what);
		$display("test failed");
		$fatal(1);
	endtask

	// **********************************************************
	// axi4-lite master
	// **********************************************************
	task automatic start_write(input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data);
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wstrb   = '1;
		wvalid  = 1'b1;
	endtask

	task automatic wait_write_accept();
		bit accepted;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clock);
			accepted = awready && wready; // transfer on the next edge.
		end
		@(posedge clock);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
	endtask

	task automatic finish_write();
		bit done;
		bready = 1'b1;
		done   = 1'b0;
		while (!done) begin
			@(negedge clock);
			done = bvalid;
		end
		check_value("write", "bresp", {30'b0, axi_resp_okay}, {30'b0, bresp});
		@(posedge clock);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_write(input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data);
		start_write(addr, data);
		wait_write_accept();
		finish_write();
	endtask

	task automatic axi_read(input logic [addr_width-1:0] addr,
		output logic [data_width-1:0] data);
		bit seen;
		araddr  = addr;
		arvalid = 1'b1;
		seen    = 1'b0;
		while (!seen) begin
			@(negedge clock);
			seen = arready;
		end
		@(posedge clock);
		#1;
		arvalid = 1'b0;
		rready  = 1'b1;
		seen    = 1'b0;
		while (!seen) begin
			@(negedge clock);
			seen = rvalid;
		end
		data = rdata;
		check_value("read", "rresp", {30'b0, axi_resp_okay}, {30'b0, rresp});
		@(posedge clock);
		#1;
		rready = 1'b0;
	endtask

	// **********************************************************
	// reference model and test table
	// **********************************************************
	function automatic void model_op(input logic [data_width-1:0] a,
		input logic [data_width-1:0] b, input logic [alu_control_width-1:0] ctl,
		input logic [func_width-1:0] fn, input logic [flag_width-1:0] prev_flag,
		output logic [data_width-1:0] res, output logic [flag_width-1:0] flg,
		output logic br);
		logic [data_width:0]     wide;
		logic [2*data_width-1:0] prod;
		logic                    is_r;
		logic                    is_add;
		logic                    is_sub;
		is_r   = (ctl == op_type_r);
		is_add = (ctl == op_addi) || (is_r && fn == fn_add);
		is_sub = (ctl == op_subi) || (is_r && fn == fn_sub);
		res    = '0;
		flg    = prev_flag; // logic ops keep the stored flag.
		br     = 1'b0;
		wide   = is_sub ? ({1'b0, a} - {1'b0, b}) : ({1'b0, a} + {1'b0, b});
		prod   = {{data_width{1'b0}}, a} * {{data_width{1'b0}}, b};
		if (is_add || is_sub) begin
			res = wide[data_width-1:0];
			if (!wide[data_width] && !wide[data_width-1])
				flg = flag_none;
			else if (wide[data_width] && !wide[data_width-1])
				flg = flag_underflow;
			else
				flg = flag_overflow;
		end else if (is_r && fn == fn_mul) begin
			res = prod[data_width-1:0];
			flg = (prod[2*data_width-1:data_width] != '0) ? flag_overflow : flag_none;
		end else if (is_r && fn == fn_div) begin
			res = (b == '0) ? '1 : a / b;
			flg = (b == '0) ? flag_exception : flag_none;
		end else if ((is_r && fn == fn_and) || ctl == op_andi) begin
			res = a & b;
		end else if ((is_r && fn == fn_or) || ctl == op_ori) begin
			res = a | b;
		end else if (is_r && fn == fn_not) begin
			res = ~b;
		end else if (ctl == op_cmp) begin
			if (a == b)
				flg = flag_equal;
			else if (a > b)
				flg = flag_above;
			else
				flg = flag_none;
		end else if (ctl == op_brfl) begin
			res = a;
			br  = (prev_flag == b[flag_width-1:0]);
		end
	endfunction

	function automatic void add_case(input string name, input logic [data_width-1:0] a,
		input logic [data_width-1:0] b, input logic [alu_control_width-1:0] ctl,
		input logic [func_width-1:0] fn, input logic [data_width-1:0] res,
		input logic [flag_width-1:0] flg, input logic br);
		name_q.push_back(name);
		a_q.push_back(a);
		b_q.push_back(b);
		ctl_q.push_back(ctl);
		fn_q.push_back(fn);
		res_q.push_back(res);
		flag_q.push_back(flg);
		br_q.push_back(br);
		stored_flag = flg;
	endfunction

	function automatic void build_table();
		add_case("addi_none", 'h5, 'h7, op_addi, '0, 'hc, flag_none, 1'b0);
		add_case("add_b31", 'h7fffffff, 'h1, op_type_r, fn_add, 'h80000000, flag_overflow, 1'b0);
		add_case("add_cy", 'hffffffff, 'h2, op_type_r, fn_add, 'h1, flag_underflow, 1'b0);
		add_case("addi_both", 'hc0000000, 'hc0000000, op_addi, '0, 'h80000000, flag_overflow,
			1'b0);
		add_case("subi_none", 'ha, 'h3, op_subi, '0, 'h7, flag_none, 1'b0);
		add_case("sub_brw", 'h3, 'h5, op_type_r, fn_sub, 'hfffffffe, flag_overflow, 1'b0);
		add_case("sub_uf", 'h0, 'h80000001, op_type_r, fn_sub, 'h7fffffff, flag_underflow, 1'b0);
		add_case("subi_b31", 'h90000000, 'h10000000, op_subi, '0, 'h80000000, flag_overflow,
			1'b0);
		add_case("mul_fits", 'h10000, 'hffff, op_type_r, fn_mul, 'hffff0000, flag_none, 1'b0);
		add_case("mul_ovf", 'h10000, 'h10000, op_type_r, fn_mul, 'h0, flag_overflow, 1'b0);
		add_case("mul_max", 'hffffffff, 'hffffffff, op_type_r, fn_mul, 'h1, flag_overflow, 1'b0);
		add_case("div_zero", 'h64, 'h0, op_type_r, fn_div, 'hffffffff, flag_exception, 1'b0);
		add_case("and_keep", 'hf0f0f0f0, 'hff00ff00, op_type_r, fn_and, 'hf000f000,
			flag_exception, 1'b0);
		add_case("or_keep", 'hf0f0f0f0, 'h0f0f0000, op_type_r, fn_or, 'hfffff0f0,
			flag_exception, 1'b0);
		add_case("not_keep", 'h12345678, 'hffff, op_type_r, fn_not, 'hffff0000,
			flag_exception, 1'b0);
		add_case("div_norm", 'h64, 'h7, op_type_r, fn_div, 'he, flag_none, 1'b0);
		add_case("mul_ovf2", 'h80000000, 'h2, op_type_r, fn_mul, 'h0, flag_overflow, 1'b0);
		add_case("andi_keep", 'habcd, 'hff, op_andi, '0, 'hcd, flag_overflow, 1'b0);
		add_case("ori_keep", 'hab00, 'hcd, op_ori, '0, 'habcd, flag_overflow, 1'b0);
		add_case("brfl_hit3", 'h400, 'h3, op_brfl, '0, 'h400, flag_overflow, 1'b1);
		add_case("brfl_miss", 'h800, 'h1, op_brfl, '0, 'h800, flag_overflow, 1'b0);
		add_case("cmp_equal", 'h55, 'h55, op_cmp, '0, 'h0, flag_equal, 1'b0);
		add_case("brfl_hit1", 'h1000, 'hfffffff9, op_brfl, '0, 'h1000, flag_equal, 1'b1);
		add_case("cmp_above", 'h80000000, 'h7fffffff, op_cmp, '0, 'h0, flag_above, 1'b0);
		add_case("brfl_hit5", 'h13572468, 'h5, op_brfl, '0, 'h13572468, flag_above, 1'b1);
		add_case("cmp_below", 'h1, 'h2, op_cmp, '0, 'h0, flag_none, 1'b0);
		add_case("brfl_hit0", 'h2468, 'h0, op_brfl, '0, 'h2468, flag_none, 1'b1);
		add_case("addi_clear", 'h1, 'h1, op_addi, '0, 'h2, flag_none, 1'b0);
	endfunction

	function automatic void add_random_cases();
		logic [data_width-1:0]        a;
		logic [data_width-1:0]        b;
		logic [data_width-1:0]        pick;
		logic [alu_control_width-1:0] ctl;
		logic [func_width-1:0]        fn;
		logic [data_width-1:0]        res;
		logic [flag_width-1:0]        flg;
		logic                         br;
		for (int n = 0; n < random_cases; n++) begin
			a    = lcg_next();
			pick = lcg_next();
			b    = lcg_next() >> pick[4:0]; // short operands now and then.
			ctl  = alu_control_width'(pick[15:8] % 8'd7);
			fn   = (ctl == op_type_r) ? r_funcs[3'(pick[23:16] % 8'd7)] : '0;
			model_op(a, b, ctl, fn, stored_flag, res, flg, br);
			add_case($sformatf("random_%0d", n), a, b, ctl, fn, res, flg, br);
		end
	endfunction

	// **********************************************************
	// test sequences
	// **********************************************************
	task automatic check_reset_values();
		logic [data_width-1:0] rd;
		axi_read(reg_result, rd);
		check_value("reset", "result", '0, rd);
		axi_read(reg_status, rd);
		check_value("reset", "status", '0, rd);
		axi_read(5'h14, rd);
		check_value("unmapped", "0x14", '0, rd);
		axi_read(5'h1c, rd);
		check_value("unmapped", "0x1c", '0, rd);
	endtask

	task automatic check_back_pressure();
		logic [data_width-1:0] rd;
		start_write(reg_data_a, 'h1111_0000);
		wait_write_accept();
		start_write(reg_data_a, 'h0000_ffff); // waits behind the first response.
		repeat (6) begin
			@(negedge clock);
			assert (bvalid && !awready && !wready)
				else stop_with_error("a second write was accepted while a response was pending");
		end
		@(posedge clock);
		#1;
		axi_read(reg_data_a, rd);
		check_value("back_pressure", "first", 'h1111_0000, rd);
		finish_write();
		wait_write_accept();
		finish_write();
		axi_read(reg_data_a, rd);
		check_value("back_pressure", "second", 'h0000_ffff, rd);
	endtask

	task automatic run_case(input int i);
		logic [data_width-1:0] op_word;
		logic [data_width-1:0] rd;
		op_word = {18'b0, fn_q[i], 5'b0, ctl_q[i]};
		axi_write(reg_data_a, a_q[i]);
		axi_write(reg_data_b, b_q[i]);
		axi_write(reg_op, op_word); // executes.
		axi_read(reg_data_a, rd);
		check_value(name_q[i], "data_a", a_q[i], rd);
		axi_read(reg_data_b, rd);
		check_value(name_q[i], "data_b", b_q[i], rd);
		axi_read(reg_op, rd);
		check_value(name_q[i], "op", op_word, rd);
		axi_read(reg_result, rd);
		check_value(name_q[i], "result", res_q[i], rd);
		axi_read(reg_status, rd);
		check_value(name_q[i], "status", {27'b0, br_q[i], 1'b0, flag_q[i]}, rd);
	endtask

	initial begin
		reset       = 1'b0;
		awaddr      = '0;
		awvalid     = 1'b0;
		wdata       = '0;
		wstrb       = '0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		error_count = 0;
		lcg_state   = 32'd58;
		stored_flag = flag_none;
		build_table();
		add_random_cases();
		table_ready = 1'b1;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b1;
		check_reset_values();
		check_back_pressure();
		for (int i = 0; i < name_q.size(); i++) begin
			run_case(i);
		end
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
common/alu_pkg.sv
alu/alu.sv
alu/flag_unit.sv
design/alu_axi_regs.sv
design/alu_top.sv
dv/alu_tb.sv

// ==== Makefile ====
TOP = alu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module alu_top

# the run passes only if the pass line shows up in the output.
sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir
